// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= ipdc_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: verification/ipdc_tb.sv
`timescale 1ns/1ps
`include "ipdc_consts.svh"

module ipdc_tb;

	localparam int CLK_PERIOD      = 100;
	localparam int WATCHDOG_CYCLES = 20000;

	logic        i_clk;
	logic        i_rst_n;
	logic        i_op_valid;
	logic [2:0]  i_op_mode;
	logic        i_in_valid;
	logic [23:0] i_in_data;
	logic        o_in_ready;
	logic        o_out_valid;
	logic [23:0] o_out_data;

	// reference model
	logic [23:0] model_img [`IPDC_PIX_CNT];
	int          model_origin;
	bit          model_ycbcr;

	// expected outputs keyed by posedge number, a key in out_sched means valid
	logic [23:0] out_sched  [int];
	bit          busy_sched [int];
	int          cyc;
	logic        exp_valid;
	logic [23:0] exp_data;
	logic        exp_ready;
	int          valid_errs;
	int          data_errs;
	int          ready_errs;

	ipdc_top i_dut (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_op_valid  (i_op_valid),
		.i_op_mode   (i_op_mode),
		.i_in_valid  (i_in_valid),
		.i_in_data   (i_in_data),
		.o_in_ready  (o_in_ready),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

	initial i_clk = 1'b0;
	always #(CLK_PERIOD / 2) i_clk = ~i_clk;

	always @(posedge i_clk) cyc <= cyc + 1;

	// expectations for the coming posedge
	always @(negedge i_clk) begin
		exp_valid = (out_sched.exists(cyc + 1) != 0);
		exp_data  = exp_valid ? out_sched[cyc + 1] : 24'h0;
		exp_ready = (busy_sched.exists(cyc + 1) == 0);
	end

	// ----------------------------------------
	// output checks
	// ----------------------------------------
	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_out_valid == exp_valid)
		else begin
			valid_errs++;
			$display("MISMATCH o_out_valid: got %h expected %h (cycle %0d)",
				$sampled(o_out_valid), $sampled(exp_valid), cyc);
		end

	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_out_data == exp_data)
		else begin
			data_errs++;
			$display("MISMATCH o_out_data: got %h expected %h (cycle %0d)",
				$sampled(o_out_data), $sampled(exp_data), cyc);
		end

	assert property (@(posedge i_clk) disable iff (!i_rst_n) o_in_ready == exp_ready)
		else begin
			ready_errs++;
			$display("MISMATCH o_in_ready: got %h expected %h (cycle %0d)",
				$sampled(o_in_ready), $sampled(exp_ready), cyc);
		end

	// ----------------------------------------
	// model of the colour conversion
	// ----------------------------------------
	// divide by 8, round up on bit 2, clip
	function automatic logic [7:0] scale_channel(input int sum);
		int q;
		q = (sum >>> 3) + ((sum >>> 2) & 1);
		if (q > `IPDC_CH_MAX) begin
			q = `IPDC_CH_MAX;
		end
		return 8'(q);
	endfunction

	function automatic logic [23:0] expected_pixel(input int idx);
		ipdc_pkg::pixel_t px;
		int r;
		int g;
		int b;
		px = model_img[idx];
		if (!model_ycbcr) begin
			return px;
		end
		r = int'(px.r);
		g = int'(px.g);
		b = int'(px.b);
		// cr high, cb middle, y low
		return {scale_channel(`IPDC_CHROMA_OFS + 4 * r - 3 * g - b),
			scale_channel(`IPDC_CHROMA_OFS + 4 * b - r - 2 * g),
			scale_channel(2 * r + 5 * g)};
	endfunction

	// ----------------------------------------
	// stimulus tasks, entered on a falling edge
	// ----------------------------------------
	task automatic wait_ready();
		while (!o_in_ready) begin
			@(negedge i_clk);
		end
	endtask

	task automatic send_op(input ipdc_pkg::op_e op);
		int acc;
		bit is_window;
		wait_ready();
		acc        = cyc + 1;
		i_op_valid = 1'b1;
		i_op_mode  = op;
		is_window  = 1'b1;
		case (op)
			ipdc_pkg::OP_SHIFT_RIGHT: begin
				if (model_origin % `IPDC_IMG_DIM < `IPDC_IMG_DIM - `IPDC_WIN_DIM) begin
					model_origin += 1;
				end
			end
			ipdc_pkg::OP_SHIFT_DOWN: begin
				if (model_origin / `IPDC_IMG_DIM < `IPDC_IMG_DIM - `IPDC_WIN_DIM) begin
					model_origin += `IPDC_IMG_DIM;
				end
			end
			ipdc_pkg::OP_ORIGIN: begin
				model_origin = 0;
			end
			ipdc_pkg::OP_MODE_YCBCR: begin
				model_ycbcr = 1'b1;
				is_window   = 1'b0;
			end
			ipdc_pkg::OP_MODE_RGB: begin
				model_ycbcr = 1'b0;
				is_window   = 1'b0;
			end
			default: begin
				is_window = 1'b0;
			end
		endcase
		if (is_window) begin
			for (int k = 0; k < `IPDC_WIN_CNT; k++) begin
				out_sched[acc + 2 + k] = expected_pixel(model_origin
					+ `IPDC_IMG_DIM * (k / `IPDC_WIN_DIM) + k % `IPDC_WIN_DIM);
				busy_sched[acc + 1 + k] = 1'b1;
			end
		end else begin
			// single done pulse carrying zero
			out_sched[acc + 2]  = 24'h0;
			busy_sched[acc + 1] = 1'b1;
		end
		@(negedge i_clk);
		i_op_valid = 1'b0;
	endtask

	task automatic load_image();
		int n;
		wait_ready();
		i_op_valid = 1'b1;
		i_op_mode  = ipdc_pkg::OP_LOAD;
		busy_sched[cyc + 2] = 1'b1;
		n = 0;
		@(negedge i_clk);
		i_op_valid = 1'b0;
		while (n < `IPDC_PIX_CNT) begin
			busy_sched[cyc + 2] = 1'b1;
			if ($urandom % 4 == 0) begin
				// gap with junk data
				i_in_valid = 1'b0;
				i_in_data  = 24'($urandom);
			end else begin
				i_in_valid = 1'b1;
				i_in_data  = model_img[n];
				n++;
			end
			@(negedge i_clk);
		end
		i_in_valid = 1'b0;
		out_sched[cyc + 2] = 24'h0;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------
	initial begin
		void'($urandom(32'he64f7fc6));
		i_rst_n      = 1'b0;
		i_op_valid   = 1'b0;
		i_op_mode    = 3'd0;
		i_in_valid   = 1'b0;
		i_in_data    = 24'h0;
		cyc          = 0;
		exp_valid    = 1'b0;
		exp_data     = 24'h0;
		exp_ready    = 1'b1;
		valid_errs   = 0;
		data_errs    = 0;
		ready_errs   = 0;
		model_origin = 0;
		model_ycbcr  = 1'b0;
		for (int i = 0; i < `IPDC_PIX_CNT; i++) begin
			model_img[i] = 24'h0;
		end
		repeat (3) @(negedge i_clk);
		i_rst_n = 1'b1;

		// cleared image gives a zero window
		send_op(ipdc_pkg::OP_ORIGIN);

		for (int i = 0; i < `IPDC_PIX_CNT; i++) begin
			model_img[i] = 24'($urandom);
		end
		// full blue and full red push cb and cr past 255
		model_img[0] = 24'hff0000;
		model_img[9] = 24'h0000ff;
		model_img[1] = 24'hffffff;
		load_image();

		send_op(ipdc_pkg::OP_ORIGIN);
		repeat (5) send_op(ipdc_pkg::OP_SHIFT_RIGHT);
		repeat (5) send_op(ipdc_pkg::OP_SHIFT_DOWN);
		send_op(ipdc_pkg::OP_ORIGIN);

		send_op(ipdc_pkg::OP_MODE_YCBCR);
		send_op(ipdc_pkg::OP_ORIGIN);
		send_op(ipdc_pkg::OP_SHIFT_DOWN);
		send_op(ipdc_pkg::OP_SHIFT_RIGHT);
		send_op(ipdc_pkg::OP_MODE_RGB);
		send_op(ipdc_pkg::OP_ORIGIN);

		// reserved codes leave origin, mode and image alone
		send_op(ipdc_pkg::OP_SHIFT_RIGHT);
		send_op(ipdc_pkg::OP_SHIFT_RIGHT);
		send_op(ipdc_pkg::OP_RSVD_ZOOM);
		send_op(ipdc_pkg::OP_RSVD_MEDIAN);
		send_op(ipdc_pkg::OP_SHIFT_DOWN);

		wait_ready();
		repeat (3) @(negedge i_clk);

		$display("errors: out_valid=%0d out_data=%0d in_ready=%0d",
			valid_errs, data_errs, ready_errs);
		if (valid_errs + data_errs + ready_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

	// watchdog
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAIL");
		$finish;
	end

endmodule

// File: verilog/color_out_stage.sv
`timescale 1ns/1ps
`include "ipdc_consts.svh"

module color_out_stage (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  ipdc_pkg::rd_req_t      i_rd_req,
	input  ipdc_pkg::pixel_t       i_pixel,
	output logic                   o_out_valid,
	output logic [`IPDC_PIX_W-1:0] o_out_data
);

	logic [11:0]      y_sum;
	logic [11:0]      cb_sum;
	logic [11:0]      cr_sum;
	ipdc_pkg::pixel_t ycc;
	ipdc_pkg::pixel_t out_pix;

	// divide by 8, round up on bit 2, clip to one channel
	function automatic logic [`IPDC_CH_W-1:0] round_sat(input logic [11:0] sum);
		logic [8:0] q;
		q = sum[11:3] + {8'b0, sum[2]};
		if (q > 9'(`IPDC_CH_MAX)) begin
			return `IPDC_CH_W'(`IPDC_CH_MAX);
		end
		return q[`IPDC_CH_W-1:0];
	endfunction

	// ----------------------------------------
	// shift-and-add conversion
	// ----------------------------------------
	// y = 2r + 5g
	assign y_sum = {3'b0, i_pixel.r, 1'b0} + {2'b0, i_pixel.g, 2'b0} + {4'b0, i_pixel.g};
	// cb = 1024 + 4b - r - 2g, never negative for 8-bit channels
	assign cb_sum = 12'(`IPDC_CHROMA_OFS) + {2'b0, i_pixel.b, 2'b0}
		- {4'b0, i_pixel.r} - {3'b0, i_pixel.g, 1'b0};
	// cr = 1024 + 4r - 3g - b
	assign cr_sum = 12'(`IPDC_CHROMA_OFS) + {2'b0, i_pixel.r, 2'b0}
		- {3'b0, i_pixel.g, 1'b0} - {4'b0, i_pixel.g} - {4'b0, i_pixel.b};

	// y low byte, cr high byte
	assign ycc.r = round_sat(y_sum);
	assign ycc.g = round_sat(cb_sum);
	assign ycc.b = round_sat(cr_sum);

	// done pulses and idle cycles carry zero
	assign out_pix = !i_rd_req.valid ? '0 : (i_rd_req.ycbcr ? ycc : i_pixel);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_out_valid <= 1'b0;
			o_out_data  <= '0;
		end else begin
			o_out_valid <= i_rd_req.valid || i_rd_req.done;
			o_out_data  <= out_pix;
		end
	end

endmodule

// File: verilog/image_buffer.sv
`timescale 1ns/1ps
`include "ipdc_consts.svh"

module image_buffer (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_wr_en,
	input  logic [`IPDC_ADDR_W-1:0] i_wr_addr,
	input  ipdc_pkg::pixel_t        i_wr_data,
	input  logic [`IPDC_ADDR_W-1:0] i_rd_addr,
	output ipdc_pkg::pixel_t        o_rd_data
);

	// one register per image pixel, row-major
	ipdc_pkg::pixel_t pix_mem [`IPDC_PIX_CNT];

	// ----------------------------------------
	// write port
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			for (int i = 0; i < `IPDC_PIX_CNT; i++) begin
				pix_mem[i] <= '0;
			end
		end else if (i_wr_en) begin
			pix_mem[i_wr_addr] <= i_wr_data;
		end
	end

	// read port, same cycle as the address
	assign o_rd_data = pix_mem[i_rd_addr];

endmodule

// File: verilog/ipdc_consts.svh
`ifndef IPDC_CONSTS_SVH
`define IPDC_CONSTS_SVH

// image and window geometry
`define IPDC_IMG_DIM 8
`define IPDC_PIX_CNT 64
`define IPDC_WIN_DIM 4
`define IPDC_WIN_CNT 16

// pixel index and data widths
`define IPDC_ADDR_W 6
`define IPDC_CH_W 8
`define IPDC_PIX_W 24

// colour conversion
`define IPDC_CH_MAX 255
// 128 scaled by 8, added before the final divide
`define IPDC_CHROMA_OFS 1024

`endif

// File: verilog/ipdc_ctrl.sv
`timescale 1ns/1ps
`include "ipdc_consts.svh"

module ipdc_ctrl (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic                    i_op_valid,
	input  logic [2:0]              i_op_mode,
	input  logic                    i_in_valid,
	output logic                    o_in_ready,
	output logic                    o_wr_en,
	output logic [`IPDC_ADDR_W-1:0] o_wr_addr,
	output logic [`IPDC_ADDR_W-1:0] o_rd_addr,
	output ipdc_pkg::rd_req_t       o_rd_req
);

	// origin column or row must stay below this for a full window
	localparam logic [2:0] POS_LIMIT = 3'(`IPDC_IMG_DIM - `IPDC_WIN_DIM);

	ipdc_pkg::ctrl_state_e   state;
	ipdc_pkg::ctrl_state_e   state_nxt;
	ipdc_pkg::op_e           op;
	logic                    op_fire;
	logic [`IPDC_ADDR_W-1:0] origin;
	logic [`IPDC_ADDR_W-1:0] origin_nxt;
	logic [`IPDC_ADDR_W-1:0] load_idx;
	logic [3:0]              disp_cnt;
	logic                    ycbcr_mode;
	logic                    load_last;
	logic                    disp_last;

	assign op         = ipdc_pkg::op_e'(i_op_mode);
	assign o_in_ready = (state == ipdc_pkg::ST_IDLE);
	assign op_fire    = i_op_valid && o_in_ready;

	// load path
	assign o_wr_en   = (state == ipdc_pkg::ST_LOAD) && i_in_valid;
	assign o_wr_addr = load_idx;
	assign load_last = o_wr_en && (load_idx == `IPDC_ADDR_W'(`IPDC_PIX_CNT - 1));

	// ----------------------------------------
	// window read address
	// ----------------------------------------
	// pixel k sits at origin + 8*(k/4) + k%4
	assign o_rd_addr = origin + {1'b0, disp_cnt[3:2], 3'b000} + {4'b0000, disp_cnt[1:0]};
	assign disp_last = (disp_cnt == 4'(`IPDC_WIN_CNT - 1));

	assign o_rd_req = '{
		valid: (state == ipdc_pkg::ST_DISPLAY),
		done:  (state == ipdc_pkg::ST_DONE),
		ycbcr: ycbcr_mode
	};

	// ----------------------------------------
	// next state and origin
	// ----------------------------------------
	always_comb begin
		state_nxt  = state;
		origin_nxt = origin;
		case (state)
			ipdc_pkg::ST_IDLE: begin
				if (op_fire) begin
					case (op)
						ipdc_pkg::OP_LOAD: begin
							state_nxt = ipdc_pkg::ST_LOAD;
						end
						ipdc_pkg::OP_SHIFT_RIGHT: begin
							// column is origin mod 8
							if (origin[2:0] < POS_LIMIT) begin
								origin_nxt = origin + 1'b1;
							end
							state_nxt = ipdc_pkg::ST_DISPLAY;
						end
						ipdc_pkg::OP_SHIFT_DOWN: begin
							// row is origin div 8
							if (origin[5:3] < POS_LIMIT) begin
								origin_nxt = origin + `IPDC_ADDR_W'(`IPDC_IMG_DIM);
							end
							state_nxt = ipdc_pkg::ST_DISPLAY;
						end
						ipdc_pkg::OP_ORIGIN: begin
							origin_nxt = '0;
							state_nxt  = ipdc_pkg::ST_DISPLAY;
						end
						// mode changes and the unused zoom/median codes
						default: begin
							state_nxt = ipdc_pkg::ST_DONE;
						end
					endcase
				end
			end
			ipdc_pkg::ST_LOAD: begin
				if (load_last) begin
					state_nxt = ipdc_pkg::ST_DONE;
				end
			end
			ipdc_pkg::ST_DISPLAY: begin
				if (disp_last) begin
					state_nxt = ipdc_pkg::ST_IDLE;
				end
			end
			default: begin
				state_nxt = ipdc_pkg::ST_IDLE;
			end
		endcase
	end

	// ----------------------------------------
	// state registers
	// ----------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			state      <= ipdc_pkg::ST_IDLE;
			origin     <= '0;
			load_idx   <= '0;
			disp_cnt   <= '0;
			ycbcr_mode <= 1'b0;
		end else begin
			state  <= state_nxt;
			origin <= origin_nxt;
			// wraps back to 0 after the 64th pixel
			if (o_wr_en) begin
				load_idx <= load_idx + 1'b1;
			end
			// wraps back to 0 after the 16th pixel
			if (state == ipdc_pkg::ST_DISPLAY) begin
				disp_cnt <= disp_cnt + 1'b1;
			end
			if (op_fire && (op == ipdc_pkg::OP_MODE_YCBCR)) begin
				ycbcr_mode <= 1'b1;
			end else if (op_fire && (op == ipdc_pkg::OP_MODE_RGB)) begin
				ycbcr_mode <= 1'b0;
			end
		end
	end

endmodule

// File: verilog/ipdc_pkg.sv
`include "ipdc_consts.svh"

package ipdc_pkg;

	// ----------------------------------------
	// operation codes on i_op_mode
	// ----------------------------------------
	typedef enum logic [2:0] {
		OP_LOAD        = 3'd0,
		OP_SHIFT_RIGHT = 3'd1,
		OP_SHIFT_DOWN  = 3'd2,
		OP_ORIGIN      = 3'd3,
		OP_RSVD_ZOOM   = 3'd4,
		OP_RSVD_MEDIAN = 3'd5,
		OP_MODE_YCBCR  = 3'd6,
		OP_MODE_RGB    = 3'd7
	} op_e;

	// controller states
	typedef enum logic [1:0] {
		ST_IDLE,
		ST_LOAD,
		ST_DISPLAY,
		ST_DONE
	} ctrl_state_e;

	// r sits in the low byte, same as the 24-bit port layout
	typedef struct packed {
		logic [`IPDC_CH_W-1:0] b;
		logic [`IPDC_CH_W-1:0] g;
		logic [`IPDC_CH_W-1:0] r;
	} pixel_t;

	// per-cycle request from controller to output stage
	typedef struct packed {
		logic valid;
		logic done;
		logic ycbcr;
	} rd_req_t;

endpackage

// File: verilog/ipdc_top.sv
`timescale 1ns/1ps
`include "ipdc_consts.svh"

module ipdc_top (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_op_valid,
	input  logic [2:0]             i_op_mode,
	input  logic                   i_in_valid,
	input  logic [`IPDC_PIX_W-1:0] i_in_data,
	output logic                   o_in_ready,
	output logic                   o_out_valid,
	output logic [`IPDC_PIX_W-1:0] o_out_data
);

	logic                    wr_en;
	logic [`IPDC_ADDR_W-1:0] wr_addr;
	logic [`IPDC_ADDR_W-1:0] rd_addr;
	ipdc_pkg::rd_req_t       rd_req;
	ipdc_pkg::pixel_t        rd_pixel;

	// ----------------------------------------
	// op decode, FSM and addressing
	// ----------------------------------------
	ipdc_ctrl u_ctrl (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_op_valid (i_op_valid),
		.i_op_mode  (i_op_mode),
		.i_in_valid (i_in_valid),
		.o_in_ready (o_in_ready),
		.o_wr_en    (wr_en),
		.o_wr_addr  (wr_addr),
		.o_rd_addr  (rd_addr),
		.o_rd_req   (rd_req)
	);

	// pixel storage, loaded straight from the input port
	image_buffer u_buf (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (wr_en),
		.i_wr_addr (wr_addr),
		.i_wr_data (ipdc_pkg::pixel_t'(i_in_data)),
		.i_rd_addr (rd_addr),
		.o_rd_data (rd_pixel)
	);

	// colour space and output register
	color_out_stage u_out (
		.i_clk       (i_clk),
		.i_rst_n     (i_rst_n),
		.i_rd_req    (rd_req),
		.i_pixel     (rd_pixel),
		.o_out_valid (o_out_valid),
		.o_out_data  (o_out_data)
	);

endmodule

// File: vlog.f
+incdir+verilog
verilog/ipdc_pkg.sv
verilog/image_buffer.sv
verilog/ipdc_ctrl.sv
verilog/color_out_stage.sv
verilog/ipdc_top.sv
verification/ipdc_tb.sv
